// File: build.f
+incdir+logic
logic/nasti_pkg.sv
logic/map_pkg.sv
logic/arbiter_rr.sv
logic/resp_mux.sv
logic/nasti_demux.sv
logic/mem_slave.sv
logic/nasti_subsys.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_nasti_subsys.sv

// File: logic/arbiter_rr.sv
// round-robin arbiter with one-hot grant and a rotating priority pointer
`timescale 1ns/100ps
`default_nettype none
`include "nasti_cfg.svh"

module arbiter_rr (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire  [`NASTI_PORTS-1:0] req,
   input  wire                     enable,
   output logic [`NASTI_PORTS-1:0] gnt
);

   localparam int PW = $clog2(`NASTI_PORTS);

   logic [PW-1:0] ptr;       // requester with the highest priority
   logic [PW-1:0] gnt_idx;   // index of the current winner

   always_comb begin
      logic [PW-1:0] idx;
      logic          found;
      gnt     = '0;
      gnt_idx = ptr;
      found   = 1'b0;
      for (int k = 0; k < `NASTI_PORTS; k++) begin
         idx = ptr + PW'(k);   // wraps by itself with a power-of-two count
         if (!found && req[idx]) begin
            found    = 1'b1;
            gnt_idx  = idx;
            gnt[idx] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         ptr <= '0;
      end else if (enable && |gnt) begin
         ptr <= gnt_idx + 1'b1;   // winner drops to lowest priority
      end
   end

endmodule

`default_nettype wire

// File: logic/map_pkg.sv
// slave port index type, address windows and the address decode function
`default_nettype none
`include "nasti_cfg.svh"

package map_pkg;

   typedef logic [$clog2(`NASTI_PORTS)-1:0] port_t;

   // 256 byte windows where a zero mask marks an unused port
   localparam nasti_pkg::addr_t BASE [`NASTI_PORTS] =
      '{16'h0000, 16'h1000, 16'h2000, 16'h3000};
   localparam nasti_pkg::addr_t MASK [`NASTI_PORTS] =
      '{16'h00ff, 16'h00ff, 16'h00ff, 16'h00ff};

   // first matching window wins and a miss falls back to port 0
   function automatic port_t port_match(input nasti_pkg::addr_t addr);
      for (int i = 0; i < `NASTI_PORTS; i++) begin
         if (MASK[i] != '0 && (addr & ~MASK[i]) == BASE[i]) begin
            return port_t'(i);
         end
      end
      return '0;
   endfunction

endpackage

`default_nettype wire

// File: logic/mem_slave.sv
// burst memory slave with a write FSM and a read beat counter
`timescale 1ns/100ps
`default_nettype none
`include "nasti_cfg.svh"

module mem_slave (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire  nasti_pkg::id_t   aw_id,
   input  wire  nasti_pkg::addr_t aw_addr,
   input  wire  nasti_pkg::len_t  aw_len,
   input  wire                    aw_valid,
   output logic                   aw_ready,
   input  wire  nasti_pkg::data_t w_data,
   input  wire                    w_last,
   input  wire                    w_valid,
   output logic                   w_ready,
   output nasti_pkg::id_t         b_id,
   output nasti_pkg::resp_t       b_resp,
   output logic                   b_valid,
   input  wire                    b_ready,
   input  wire  nasti_pkg::id_t   ar_id,
   input  wire  nasti_pkg::addr_t ar_addr,
   input  wire  nasti_pkg::len_t  ar_len,
   input  wire                    ar_valid,
   output logic                   ar_ready,
   output nasti_pkg::id_t         r_id,
   output nasti_pkg::data_t       r_data,
   output nasti_pkg::resp_t       r_resp,
   output logic                   r_last,
   output logic                   r_valid,
   input  wire                    r_ready
);

   localparam int AW  = $clog2(`MEM_WORDS);
   localparam int OFS = $clog2(`NASTI_DATA_W / 8);   // byte offset inside a word

   typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_t;

   w_state_t               w_state;
   logic                   ready_en;   // first cycle out of reset reached
   logic [AW-1:0]          w_addr;
   logic [`NASTI_LEN_W:0]  w_left;     // beats the aw announced and not yet stored
   logic [AW-1:0]          r_addr;
   logic [`NASTI_LEN_W-1:0] r_cnt;     // beats left after the current one
   logic                   r_act;
   nasti_pkg::data_t       mem [`MEM_WORDS];

   assign aw_ready = ready_en && w_state == W_IDLE;
   assign w_ready  = w_state == W_DATA;
   assign b_valid  = w_state == W_RESP;
   assign b_resp   = nasti_pkg::RESP_OKAY;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         ready_en <= 1'b0;
         w_state  <= W_IDLE;
         w_left   <= '0;
      end else begin
         ready_en <= 1'b1;
         case (w_state)
            W_IDLE: begin
               if (aw_valid && aw_ready) begin
                  w_state <= W_DATA;
                  w_left  <= {1'b0, aw_len} + 1'b1;
               end
            end
            W_DATA: begin
               if (w_valid) begin
                  if (w_left != '0) begin
                     w_left <= w_left - 1'b1;
                  end
                  if (w_last) begin
                     w_state <= W_RESP;   // response goes out next cycle
                  end
               end
            end
            default: begin
               if (b_ready) begin
                  w_state <= W_IDLE;
               end
            end
         endcase
      end
   end

   // beats past the announced length are accepted but not stored
   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) begin
         w_addr <= aw_addr[OFS +: AW];
         b_id   <= aw_id;
      end else if (w_valid && w_ready) begin
         w_addr <= w_addr + 1'b1;
         if (w_left != '0) begin
            mem[w_addr] <= w_data;
         end
      end
   end

   assign ar_ready = ready_en && !r_act;
   assign r_valid  = r_act;
   assign r_data   = mem[r_addr];
   assign r_resp   = nasti_pkg::RESP_OKAY;
   assign r_last   = r_cnt == '0;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         r_act <= 1'b0;
         r_cnt <= '0;
      end else if (ar_valid && ar_ready) begin
         r_act <= 1'b1;
         r_cnt <= ar_len;
      end else if (r_valid && r_ready) begin
         r_act <= !r_last;
         r_cnt <= r_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_valid && ar_ready) begin
         r_addr <= ar_addr[OFS +: AW];   // upper window bits dropped here
         r_id   <= ar_id;
      end else if (r_valid && r_ready) begin
         r_addr <= r_addr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: logic/nasti_cfg.svh
// bus field widths, slave port count, burst length limit and memory depth
`ifndef NASTI_CFG_SVH
`define NASTI_CFG_SVH

`define NASTI_ID_W   2    // transaction id
`define NASTI_ADDR_W 16   // byte address
`define NASTI_DATA_W 32   // one full word per beat
`define NASTI_LEN_W  4    // beats minus one so at most 16 beats
`define NASTI_PORTS  4    // slave ports kept to a power of two
`define MEM_WORDS    64   // words per memory slave

`endif

// File: logic/nasti_demux.sv
// address decode and fan-out of the aw, w and ar channels with write lock
// b and r responses merged back through two round-robin response muxes
`timescale 1ns/100ps
`default_nettype none
`include "nasti_cfg.svh"

module nasti_demux (
   input  wire                          clk,
   input  wire                          rstn,
   // master side
   input  wire  nasti_pkg::id_t         aw_id,
   input  wire  nasti_pkg::addr_t       aw_addr,
   input  wire  nasti_pkg::len_t        aw_len,
   input  wire                          aw_valid,
   output logic                         aw_ready,
   input  wire  nasti_pkg::data_t       w_data,
   input  wire                          w_last,
   input  wire                          w_valid,
   output logic                         w_ready,
   output nasti_pkg::id_t               b_id,
   output nasti_pkg::resp_t             b_resp,
   output logic                         b_valid,
   input  wire                          b_ready,
   input  wire  nasti_pkg::id_t         ar_id,
   input  wire  nasti_pkg::addr_t       ar_addr,
   input  wire  nasti_pkg::len_t        ar_len,
   input  wire                          ar_valid,
   output logic                         ar_ready,
   output nasti_pkg::id_t               r_id,
   output nasti_pkg::data_t             r_data,
   output nasti_pkg::resp_t             r_resp,
   output logic                         r_last,
   output logic                         r_valid,
   input  wire                          r_ready,
   // slave side indexed by port
   output nasti_pkg::id_t               s_aw_id    [`NASTI_PORTS],
   output nasti_pkg::addr_t             s_aw_addr  [`NASTI_PORTS],
   output nasti_pkg::len_t              s_aw_len   [`NASTI_PORTS],
   output logic [`NASTI_PORTS-1:0]      s_aw_valid,
   input  wire  [`NASTI_PORTS-1:0]      s_aw_ready,
   output nasti_pkg::data_t             s_w_data   [`NASTI_PORTS],
   output logic [`NASTI_PORTS-1:0]      s_w_last,
   output logic [`NASTI_PORTS-1:0]      s_w_valid,
   input  wire  [`NASTI_PORTS-1:0]      s_w_ready,
   input  wire  nasti_pkg::id_t         s_b_id     [`NASTI_PORTS],
   input  wire  nasti_pkg::resp_t       s_b_resp   [`NASTI_PORTS],
   input  wire  [`NASTI_PORTS-1:0]      s_b_valid,
   output logic [`NASTI_PORTS-1:0]      s_b_ready,
   output nasti_pkg::id_t               s_ar_id    [`NASTI_PORTS],
   output nasti_pkg::addr_t             s_ar_addr  [`NASTI_PORTS],
   output nasti_pkg::len_t              s_ar_len   [`NASTI_PORTS],
   output logic [`NASTI_PORTS-1:0]      s_ar_valid,
   input  wire  [`NASTI_PORTS-1:0]      s_ar_ready,
   input  wire  nasti_pkg::id_t         s_r_id     [`NASTI_PORTS],
   input  wire  nasti_pkg::data_t       s_r_data   [`NASTI_PORTS],
   input  wire  nasti_pkg::resp_t       s_r_resp   [`NASTI_PORTS],
   input  wire  [`NASTI_PORTS-1:0]      s_r_last,
   input  wire  [`NASTI_PORTS-1:0]      s_r_valid,
   output logic [`NASTI_PORTS-1:0]      s_r_ready
);

   logic                   lock;          // aw taken and w beats still to come
   map_pkg::port_t         locked_port;
   map_pkg::port_t         aw_sel;
   map_pkg::port_t         ar_sel;
   nasti_pkg::b_payload_t  b_in [`NASTI_PORTS];
   nasti_pkg::b_payload_t  b_out;
   nasti_pkg::r_payload_t  r_in [`NASTI_PORTS];
   nasti_pkg::r_payload_t  r_out;

   assign aw_sel = lock ? locked_port : map_pkg::port_match(aw_addr);
   assign ar_sel = map_pkg::port_match(ar_addr);   // reads never lock

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         lock        <= 1'b0;
         locked_port <= '0;
      end else if (aw_valid && aw_ready) begin
         lock        <= 1'b1;
         locked_port <= aw_sel;
      end else if (w_valid && w_ready && w_last) begin
         lock <= 1'b0;
      end
   end

   for (genvar i = 0; i < `NASTI_PORTS; i++) begin : g_port
      assign s_aw_id[i]    = aw_id;
      assign s_aw_addr[i]  = aw_addr;
      assign s_aw_len[i]   = aw_len;
      assign s_aw_valid[i] = !lock && aw_sel == map_pkg::port_t'(i) && aw_valid;
      assign s_w_data[i]   = w_data;
      assign s_w_last[i]   = w_last;
      assign s_w_valid[i]  = lock && aw_sel == map_pkg::port_t'(i) && w_valid;
      assign s_ar_id[i]    = ar_id;
      assign s_ar_addr[i]  = ar_addr;
      assign s_ar_len[i]   = ar_len;
      assign s_ar_valid[i] = ar_sel == map_pkg::port_t'(i) && ar_valid;
      assign b_in[i]       = '{id: s_b_id[i], resp: s_b_resp[i]};
      assign r_in[i]       = '{id:   s_r_id[i],
                               data: s_r_data[i],
                               resp: s_r_resp[i],
                               last: s_r_last[i]};
   end

   assign aw_ready = !lock && s_aw_ready[aw_sel];
   assign w_ready  = lock && s_w_ready[aw_sel];
   assign ar_ready = s_ar_ready[ar_sel];

   resp_mux #(.payload_t(nasti_pkg::b_payload_t)) u_b_mux (
      .clk       (clk),
      .rstn      (rstn),
      .s_valid   (s_b_valid),
      .s_payload (b_in),
      .s_ready   (s_b_ready),
      .m_valid   (b_valid),
      .m_payload (b_out),
      .m_ready   (b_ready),
      .m_last    (1'b1)   // a write response is a single beat
   );

   assign b_id   = b_out.id;
   assign b_resp = b_out.resp;

   resp_mux #(.payload_t(nasti_pkg::r_payload_t)) u_r_mux (
      .clk       (clk),
      .rstn      (rstn),
      .s_valid   (s_r_valid),
      .s_payload (r_in),
      .s_ready   (s_r_ready),
      .m_valid   (r_valid),
      .m_payload (r_out),
      .m_ready   (r_ready),
      .m_last    (r_out.last)
   );

   assign r_id   = r_out.id;
   assign r_data = r_out.data;
   assign r_resp = r_out.resp;
   assign r_last = r_out.last;

endmodule

`default_nettype wire

// File: logic/nasti_pkg.sv
// channel field types and the packed write-response and read-data payloads
`default_nettype none
`include "nasti_cfg.svh"

package nasti_pkg;

   typedef logic [`NASTI_ID_W-1:0]   id_t;
   typedef logic [`NASTI_ADDR_W-1:0] addr_t;
   typedef logic [`NASTI_DATA_W-1:0] data_t;
   typedef logic [`NASTI_LEN_W-1:0]  len_t;

   typedef logic [1:0] resp_t;
   localparam resp_t RESP_OKAY = 2'b00;   // the only response ever returned

   typedef struct packed {
      id_t   id;
      resp_t resp;
   } b_payload_t;

   typedef struct packed {
      id_t   id;
      data_t data;
      resp_t resp;
      logic  last;
   } r_payload_t;

endpackage

`default_nettype wire

// File: logic/nasti_subsys.sv
// top level with the address demux in front of four burst memory slaves
`timescale 1ns/100ps
`default_nettype none
`include "nasti_cfg.svh"

module nasti_subsys (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire  nasti_pkg::id_t   aw_id,
   input  wire  nasti_pkg::addr_t aw_addr,
   input  wire  nasti_pkg::len_t  aw_len,
   input  wire                    aw_valid,
   output wire                    aw_ready,
   input  wire  nasti_pkg::data_t w_data,
   input  wire                    w_last,
   input  wire                    w_valid,
   output wire                    w_ready,
   output wire  nasti_pkg::id_t   b_id,
   output wire  nasti_pkg::resp_t b_resp,
   output wire                    b_valid,
   input  wire                    b_ready,
   input  wire  nasti_pkg::id_t   ar_id,
   input  wire  nasti_pkg::addr_t ar_addr,
   input  wire  nasti_pkg::len_t  ar_len,
   input  wire                    ar_valid,
   output wire                    ar_ready,
   output wire  nasti_pkg::id_t   r_id,
   output wire  nasti_pkg::data_t r_data,
   output wire  nasti_pkg::resp_t r_resp,
   output wire                    r_last,
   output wire                    r_valid,
   input  wire                    r_ready
);

   wire nasti_pkg::id_t         s_aw_id    [`NASTI_PORTS];
   wire nasti_pkg::addr_t       s_aw_addr  [`NASTI_PORTS];
   wire nasti_pkg::len_t        s_aw_len   [`NASTI_PORTS];
   wire [`NASTI_PORTS-1:0]      s_aw_valid;
   wire [`NASTI_PORTS-1:0]      s_aw_ready;
   wire nasti_pkg::data_t       s_w_data   [`NASTI_PORTS];
   wire [`NASTI_PORTS-1:0]      s_w_last;
   wire [`NASTI_PORTS-1:0]      s_w_valid;
   wire [`NASTI_PORTS-1:0]      s_w_ready;
   wire nasti_pkg::id_t         s_b_id     [`NASTI_PORTS];
   wire nasti_pkg::resp_t       s_b_resp   [`NASTI_PORTS];
   wire [`NASTI_PORTS-1:0]      s_b_valid;
   wire [`NASTI_PORTS-1:0]      s_b_ready;
   wire nasti_pkg::id_t         s_ar_id    [`NASTI_PORTS];
   wire nasti_pkg::addr_t       s_ar_addr  [`NASTI_PORTS];
   wire nasti_pkg::len_t        s_ar_len   [`NASTI_PORTS];
   wire [`NASTI_PORTS-1:0]      s_ar_valid;
   wire [`NASTI_PORTS-1:0]      s_ar_ready;
   wire nasti_pkg::id_t         s_r_id     [`NASTI_PORTS];
   wire nasti_pkg::data_t       s_r_data   [`NASTI_PORTS];
   wire nasti_pkg::resp_t       s_r_resp   [`NASTI_PORTS];
   wire [`NASTI_PORTS-1:0]      s_r_last;
   wire [`NASTI_PORTS-1:0]      s_r_valid;
   wire [`NASTI_PORTS-1:0]      s_r_ready;

   nasti_demux u_demux (.*);   // port names match on both sides

   for (genvar i = 0; i < `NASTI_PORTS; i++) begin : g_mem
      mem_slave u_mem (
         .clk      (clk),
         .rstn     (rstn),
         .aw_id    (s_aw_id[i]),
         .aw_addr  (s_aw_addr[i]),
         .aw_len   (s_aw_len[i]),
         .aw_valid (s_aw_valid[i]),
         .aw_ready (s_aw_ready[i]),
         .w_data   (s_w_data[i]),
         .w_last   (s_w_last[i]),
         .w_valid  (s_w_valid[i]),
         .w_ready  (s_w_ready[i]),
         .b_id     (s_b_id[i]),
         .b_resp   (s_b_resp[i]),
         .b_valid  (s_b_valid[i]),
         .b_ready  (s_b_ready[i]),
         .ar_id    (s_ar_id[i]),
         .ar_addr  (s_ar_addr[i]),
         .ar_len   (s_ar_len[i]),
         .ar_valid (s_ar_valid[i]),
         .ar_ready (s_ar_ready[i]),
         .r_id     (s_r_id[i]),
         .r_data   (s_r_data[i]),
         .r_resp   (s_r_resp[i]),
         .r_last   (s_r_last[i]),
         .r_valid  (s_r_valid[i]),
         .r_ready  (s_r_ready[i])
      );
   end

endmodule

`default_nettype wire

// File: logic/resp_mux.sv
// response merge from all slaves to the master, holding the grant for a whole burst
`timescale 1ns/100ps
`default_nettype none
`include "nasti_cfg.svh"

module resp_mux #(
   parameter type payload_t = nasti_pkg::b_payload_t
) (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire  [`NASTI_PORTS-1:0] s_valid,
   input  wire  payload_t          s_payload [`NASTI_PORTS],
   output logic [`NASTI_PORTS-1:0] s_ready,
   output logic                    m_valid,
   output payload_t                m_payload,
   input  wire                     m_ready,
   input  wire                     m_last
);

   logic [`NASTI_PORTS-1:0] req;
   logic [`NASTI_PORTS-1:0] arb_gnt;
   logic [`NASTI_PORTS-1:0] held;   // slave owning the burst in progress
   logic [`NASTI_PORTS-1:0] sel;
   logic                    locked;

   always_comb begin
      for (int i = 0; i < `NASTI_PORTS; i++) begin
         req[i] = s_valid[i] && (map_pkg::MASK[i] != '0);   // unused ports never win
      end
   end

   arbiter_rr u_arb (
      .clk    (clk),
      .rstn   (rstn),
      .req    (req),
      .enable (m_valid && m_ready && !locked),   // rotate once per burst
      .gnt    (arb_gnt)
   );

   assign sel     = locked ? held : arb_gnt;
   assign m_valid = |(sel & req);
   assign s_ready = m_ready ? sel : '0;

   always_comb begin
      m_payload = s_payload[0];
      for (int i = 0; i < `NASTI_PORTS; i++) begin
         if (sel[i]) begin
            m_payload = s_payload[i];
         end
      end
   end

   // a transferred beat without last keeps the grant until the burst ends
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         locked <= 1'b0;
         held   <= '0;
      end else if (m_valid && m_ready) begin
         locked <= !m_last;
         held   <= sel;
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile the subsystem and its testbench with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_nasti_subsys \
   -o tb_nasti_subsys

out=$(./obj_dir/tb_nasti_subsys)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: testbench/golden_vectors.txt
# columns in hex: op id addr len data, op 0 write, 1 read, 2 read beside the next line's write
# len is beats minus one, beat k carries data+k, a read's data is the first word it must return
0 0 0000 3 a0000000
0 1 1000 3 b1000000
0 2 2000 3 c2000000
0 3 3000 3 d3000000
1 1 0000 3 a0000000
1 2 1000 3 b1000000
1 3 2000 3 c2000000
1 0 3000 3 d3000000
0 2 1040 0 11110000
1 3 1040 0 11110000
0 1 2080 f 22220000
1 0 2080 f 22220000
0 3 5044 3 33330000
1 2 0044 3 33330000
2 1 2080 f 22220000
0 2 30c0 f 55550000
1 3 30c0 f 55550000
1 0 5044 3 33330000

// File: testbench/tb_checker.sv
// master-side monitor with expected write-response and read-beat queues
// compares every b and r handshake and keeps the error counts
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire  nasti_pkg::id_t   b_id,
   input  wire  nasti_pkg::resp_t b_resp,
   input  wire                    b_valid,
   input  wire                    b_ready,
   input  wire  nasti_pkg::id_t   r_id,
   input  wire  nasti_pkg::data_t r_data,
   input  wire  nasti_pkg::resp_t r_resp,
   input  wire                    r_last,
   input  wire                    r_valid,
   input  wire                    r_ready,
   output int                     b_done,   // write responses taken
   output int                     r_done    // read bursts closed by r_last
);

   nasti_pkg::b_payload_t exp_b_q [$];
   nasti_pkg::r_payload_t exp_r_q [$];
   int                    mismatches = 0;
   int                    unexpected = 0;   // beats with nothing outstanding

   task automatic expect_write(input nasti_pkg::id_t id);
      nasti_pkg::b_payload_t want;
      want.id   = id;
      want.resp = nasti_pkg::RESP_OKAY;
      exp_b_q.push_back(want);
   endtask

   task automatic expect_read(input nasti_pkg::id_t id, input nasti_pkg::data_t data,
                              input logic last);
      nasti_pkg::r_payload_t want;
      want.id   = id;
      want.data = data;
      want.resp = nasti_pkg::RESP_OKAY;
      want.last = last;
      exp_r_q.push_back(want);
   endtask

   task automatic compare_field(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic check_write_resp();
      nasti_pkg::b_payload_t want;
      if (exp_b_q.size() == 0) begin
         $display("at %0t a write response with id %0d came with no write outstanding",
                  $time, b_id);
         unexpected++;
      end else begin
         want = exp_b_q.pop_front();
         compare_field("b_id", 32'(want.id), 32'(b_id));
         compare_field("b_resp", 32'(want.resp), 32'(b_resp));
      end
   endtask

   task automatic check_read_beat();
      nasti_pkg::r_payload_t want;
      if (exp_r_q.size() == 0) begin
         $display("at %0t a read beat with id %0d came with no read outstanding",
                  $time, r_id);
         unexpected++;
      end else begin
         want = exp_r_q.pop_front();
         compare_field("r_id", 32'(want.id), 32'(r_id));
         compare_field("r_data", want.data, r_data);
         compare_field("r_resp", 32'(want.resp), 32'(r_resp));
         compare_field("r_last", 32'(want.last), 32'(r_last));
      end
   endtask

   function automatic int total_errors();
      return mismatches + unexpected + exp_b_q.size() + exp_r_q.size();
   endfunction

   task automatic print_summary();
      if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
         $display("%0d write responses and %0d read beats were expected but never arrived",
                  exp_b_q.size(), exp_r_q.size());
      end
      $display("errors: %0d wrong values, %0d unexpected beats, %0d missing responses",
               mismatches, unexpected, exp_b_q.size() + exp_r_q.size());
   endtask

   // values seen here are the ones present before the edge
   always @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         b_done <= 0;
         r_done <= 0;
      end else begin
         if (b_valid && b_ready) begin
            check_write_resp();
            b_done <= b_done + 1;
         end
         if (r_valid && r_ready) begin
            check_read_beat();
            if (r_last) begin
               r_done <= r_done + 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
// testbench clock of 40 ns period and an active-low reset held for 5 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rstn
);

   localparam int HALF_NS = 20;

   initial begin
      clk = 1'b0;
      forever #HALF_NS clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (5) @(negedge clk);   // release away from the rising edge
      rstn = 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/tb_nasti_subsys.sv
// testbench top with the golden vector reader, falling-edge burst driver,
// random b and r back-pressure and the cycle timeout
`timescale 1ns/100ps
`default_nettype none

module tb_nasti_subsys;

   logic             clk;
   logic             rstn;
   nasti_pkg::id_t   aw_id;
   nasti_pkg::addr_t aw_addr;
   nasti_pkg::len_t  aw_len;
   logic             aw_valid;
   logic             aw_ready;
   nasti_pkg::data_t w_data;
   logic             w_last;
   logic             w_valid;
   logic             w_ready;
   nasti_pkg::id_t   b_id;
   nasti_pkg::resp_t b_resp;
   logic             b_valid;
   logic             b_ready;
   nasti_pkg::id_t   ar_id;
   nasti_pkg::addr_t ar_addr;
   nasti_pkg::len_t  ar_len;
   logic             ar_valid;
   logic             ar_ready;
   nasti_pkg::id_t   r_id;
   nasti_pkg::data_t r_data;
   nasti_pkg::resp_t r_resp;
   logic             r_last;
   logic             r_valid;
   logic             r_ready;

   int          b_done;
   int          r_done;
   int          b_issued = 0;
   int          r_issued = 0;
   int          cycles   = 0;
   int          limit    = 0;   // set once the vectors are known
   logic [31:0] op_q   [$];     // 0 write, 1 read, 2 read beside the next write
   logic [31:0] id_q   [$];
   logic [31:0] addr_q [$];
   logic [31:0] len_q  [$];
   logic [31:0] data_q [$];     // first word where beat k carries data + k

   tb_clock u_clk (.clk(clk), .rstn(rstn));

   nasti_subsys uut (.*);

   tb_checker u_chk (.*);

   task automatic load_vectors();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_op;
      logic [31:0] f_id;
      logic [31:0] f_addr;
      logic [31:0] f_len;
      logic [31:0] f_data;
      fd = $fopen("testbench/golden_vectors.txt", "r");
      if (fd == 0) begin
         $display("the golden vector file testbench/golden_vectors.txt could not be opened");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h", f_op, f_id, f_addr, f_len, f_data);
               if (n == 5) begin
                  op_q.push_back(f_op);
                  id_q.push_back(f_id);
                  addr_q.push_back(f_addr);
                  len_q.push_back(f_len);
                  data_q.push_back(f_data);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic write_burst(input int idx);
      int k;
      int target;
      u_chk.expect_write(nasti_pkg::id_t'(id_q[idx]));
      b_issued++;
      target = b_issued;
      @(negedge clk);
      aw_id    = nasti_pkg::id_t'(id_q[idx]);
      aw_addr  = nasti_pkg::addr_t'(addr_q[idx]);
      aw_len   = nasti_pkg::len_t'(len_q[idx]);
      aw_valid = 1'b1;
      #1;
      while (!aw_ready) begin
         @(negedge clk);
         #1;
      end
      @(posedge clk);
      for (k = 0; k <= int'(len_q[idx]); k++) begin
         @(negedge clk);
         aw_valid = 1'b0;
         w_data   = data_q[idx] + 32'(k);
         w_last   = (k == int'(len_q[idx]));
         w_valid  = 1'b1;
         #1;
         while (!w_ready) begin
            @(negedge clk);
            #1;
         end
         @(posedge clk);
      end
      @(negedge clk);
      w_valid = 1'b0;
      w_last  = 1'b0;
      while (b_done < target) @(negedge clk);
   endtask

   task automatic read_burst(input int idx);
      int k;
      int target;
      for (k = 0; k <= int'(len_q[idx]); k++) begin
         u_chk.expect_read(nasti_pkg::id_t'(id_q[idx]), data_q[idx] + 32'(k),
                           k == int'(len_q[idx]));
      end
      r_issued++;
      target = r_issued;
      @(negedge clk);
      ar_id    = nasti_pkg::id_t'(id_q[idx]);
      ar_addr  = nasti_pkg::addr_t'(addr_q[idx]);
      ar_len   = nasti_pkg::len_t'(len_q[idx]);
      ar_valid = 1'b1;
      #1;
      while (!ar_ready) begin
         @(negedge clk);
         #1;
      end
      @(posedge clk);
      @(negedge clk);
      ar_valid = 1'b0;
      while (r_done < target) @(negedge clk);
   endtask

   always @(negedge clk) begin
      r_ready = ($urandom % 4) != 0;   // about three beats in four taken
      b_ready = ($urandom % 3) != 0;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         $display("timeout after %0d cycles, the bursts did not all complete", cycles);
         u_chk.print_summary();
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      int i;
      void'($urandom(32'h7314));
      aw_id    = '0;
      aw_addr  = '0;
      aw_len   = '0;
      aw_valid = 1'b0;
      w_data   = '0;
      w_last   = 1'b0;
      w_valid  = 1'b0;
      b_ready  = 1'b0;
      ar_id    = '0;
      ar_addr  = '0;
      ar_len   = '0;
      ar_valid = 1'b0;
      r_ready  = 1'b0;
      load_vectors();
      if (op_q.size() == 0) begin
         $display("no bursts could be read from the golden vector file");
         $display("Something failed");
      end else begin
         limit = 40 * op_q.size() + 200;
         wait (rstn === 1'b1);
         i = 0;
         while (i < op_q.size()) begin
            if (op_q[i] == 0) begin
               write_burst(i);
               i = i + 1;
            end else if (op_q[i] == 2 && i + 1 < op_q.size()) begin
               fork   // read on one port while the next line writes another
                  read_burst(i);
                  write_burst(i + 1);
               join
               i = i + 2;
            end else begin
               read_burst(i);
               i = i + 1;
            end
         end
         repeat (4) @(negedge clk);
         u_chk.print_summary();
         if (u_chk.total_errors() == 0) begin
            $display("Everything OK");
         end else begin
            $display("Something failed");
         end
      end
      $finish;
   end

endmodule

`default_nettype wire
